//--- rv_cases.txt
// Block: test number, instruction count, store count (hex), then the instruction words,
// then the expected store address and data pairs in order. A test number of 0 ends the list.
1 1 0
0000006F
2 10 6
00500093 00308113 401101B3 0030C233 00211293 0042E333 FFF00393 4043D413
0013A4B3 00202023 00302223 00402423 00602623 00802823 00902A23 0000006F
00000000 00000008 00000004 00000003 00000008 00000006
0000000C 00000026 00000010 FFFFFFFF 00000014 00000001
3 5 2
123450B7 00001117 00102023 00202223 0000006F
00000000 12345000 00000004 00001004
4 18 5
00100093 00200113 FFF00193 00208463 00102023 00209463 00302023 0011C463
00302023 0011D463 00202223 0011E463 00102423 0011F463 00302023 008002EF
00302023 00502623 05800313 000303E7 00302023 00302023 00702823 0000006F
00000000 00000001 00000004 00000002 00000008 00000001
0000000C 00000040 00000010 00000050
5 7 3
05A00093 02102023 02002103 00110193 02302223 02202423 0000006F
00000020 0000005A 00000024 0000005B 00000028 0000005A
0 0 0

//--- build.f
+incdir+.
rv_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
rv_core.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_rv_core -o tb_sim || exit 1
out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

//--- tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module tb_rv_core;

    logic             CLK;
    logic             reset;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    logic             dmem_enable;
    logic             dmem_write;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic [`XLEN-1:0] dmem_rdata;

    logic [31:0] cases_mem [0:511];
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] n_instr;
    int          ptr;
    int          pass_count;
    int          fail_count;

    rv_core u_dut
    (
        .CLK         (CLK),
        .reset       (reset),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .dmem_enable (dmem_enable),
        .dmem_write  (dmem_write),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_rdata  (dmem_rdata)
    );

    // ----------------------------------------
    // Memory models
    // ----------------------------------------
    assign imem_data = (imem_addr < (n_instr << 2)) ? imem[imem_addr[7:2]] : `NOP_WORD;
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    // Data memory is cleared while the core is in reset
    always @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < 64; i++)
                dmem[i] <= '0;
        end
        else if (dmem_enable && dmem_write)
            dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic check_reset_state(input string name, input string phase, inout bit ok);
        if (imem_addr !== `RESET_ADDRESS)
        begin
            $display("FAILED %s imem_addr %s expected %h actual %h", name, phase,
                     `RESET_ADDRESS, imem_addr);
            ok = 0;
        end
        if (dmem_enable !== 1'b0)
        begin
            $display("FAILED %s dmem_enable %s expected 0 actual %b", name, phase, dmem_enable);
            ok = 0;
        end
    endtask

    task automatic run_case();
        string       name;
        bit          ok;
        bit          got;
        int          cycles;
        int          n_store;
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        name = $sformatf("case_%0d", cases_mem[ptr]);
        n_instr = cases_mem[ptr + 1];
        n_store = cases_mem[ptr + 2];
        ptr = ptr + 3;
        ok = 1;
        for (int i = 0; i < 64; i++)
            imem[i] = (i < n_instr) ? cases_mem[ptr + i] : `NOP_WORD;
        ptr = ptr + n_instr;
        @(posedge CLK);
        #1 reset = 1'b1;
        @(posedge CLK);
        #1 check_reset_state(name, "during reset", ok);
        @(posedge CLK);
        #1 reset = 1'b0;
        check_reset_state(name, "after reset", ok);
        for (int k = 0; k < n_store && ok; k++)
        begin
            exp_addr = cases_mem[ptr + 2 * k];
            exp_data = cases_mem[ptr + 2 * k + 1];
            got = 0;
            cycles = 0;
            while (!got && cycles < 300)
            begin
                @(negedge CLK);
                if (dmem_enable && dmem_write)
                    got = 1;
                else
                    cycles++;
            end
            if (!got)
            begin
                $display("%s timed out waiting for store number %0d", name, k);
                ok = 0;
            end
            else
            begin
                if (dmem_addr !== exp_addr)
                begin
                    $display("FAILED %s store address expected %h actual %h", name,
                             exp_addr, dmem_addr);
                    ok = 0;
                end
                if (dmem_wdata !== exp_data)
                begin
                    $display("FAILED %s store data expected %h actual %h", name,
                             exp_data, dmem_wdata);
                    ok = 0;
                end
            end
        end
        ptr = ptr + 2 * n_store;
        // The program now spins on its last jump and must store nothing more
        for (int c = 0; c < 20 && ok; c++)
        begin
            @(negedge CLK);
            if (dmem_enable && dmem_write)
            begin
                $display("%s made an extra store to address %h", name, dmem_addr);
                ok = 0;
            end
        end
        if (ok)
        begin
            pass_count++;
            $display("%s passed", name);
        end
        else
        begin
            fail_count++;
            $display("%s failed", name);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        n_instr = '0;
        ptr = 0;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < 512; i++)
            cases_mem[i] = '0;
        $readmemh("rv_cases.txt", cases_mem);
        while (ptr < 480 && cases_mem[ptr] != 0)
            run_case();
        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- rv_core.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic             CLK,
    input  logic             reset,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_data,
    output logic             dmem_enable,
    output logic             dmem_write,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    input  logic [`XLEN-1:0] dmem_rdata
);

    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;
    logic                   stall;
    logic                   flush;
    logic [`XLEN-1:0]       if_pc;
    instr_u                 if_instr;
    fwd_sel_e               fwd_sel_1;
    fwd_sel_e               fwd_sel_2;
    logic [`XLEN-1:0]       ex_fwd_data;
    logic [`XLEN-1:0]       mem_fwd_data;
    logic [`REG_ADDR_W-1:0] rs1_index;
    logic [`REG_ADDR_W-1:0] rs2_index;
    logic                   rs1_used;
    logic                   rs2_used;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;
    mem_wb_t                wb;

    // Both a redirect and a load-use stall kill the decode instruction
    assign flush = redirect | stall;

    fetch_stage u_fetch_stage
    (
        .CLK         (CLK),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_pc       (if_pc),
        .if_instr    (if_instr)
    );

    decode_stage u_decode_stage
    (
        .CLK          (CLK),
        .reset        (reset),
        .if_pc        (if_pc),
        .if_instr     (if_instr),
        .flush        (flush),
        .fwd_sel_1    (fwd_sel_1),
        .fwd_sel_2    (fwd_sel_2),
        .ex_fwd_data  (ex_fwd_data),
        .mem_fwd_data (mem_fwd_data),
        .wb           (wb),
        .rs1_index    (rs1_index),
        .rs2_index    (rs2_index),
        .rs1_used     (rs1_used),
        .rs2_used     (rs2_used),
        .id_ex        (id_ex)
    );

    hazard_unit u_hazard_unit
    (
        .rs1_index (rs1_index),
        .rs2_index (rs2_index),
        .rs1_used  (rs1_used),
        .rs2_used  (rs2_used),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .wb        (wb),
        .fwd_sel_1 (fwd_sel_1),
        .fwd_sel_2 (fwd_sel_2),
        .stall     (stall)
    );

    execute_stage u_execute_stage
    (
        .CLK         (CLK),
        .reset       (reset),
        .id_ex       (id_ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_fwd_data (ex_fwd_data),
        .ex_mem      (ex_mem)
    );

    memory_stage u_memory_stage
    (
        .CLK          (CLK),
        .reset        (reset),
        .ex_mem       (ex_mem),
        .dmem_enable  (dmem_enable),
        .dmem_write   (dmem_write),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata),
        .mem_fwd_data (mem_fwd_data),
        .wb           (wb)
    );

endmodule

//--- memory_stage.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module memory_stage
    import rv_pkg::*;
(
    input  logic             CLK,
    input  logic             reset,
    input  ex_mem_t          ex_mem,
    output logic             dmem_enable,
    output logic             dmem_write,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    input  logic [`XLEN-1:0] dmem_rdata,
    output logic [`XLEN-1:0] mem_fwd_data,
    output mem_wb_t          wb
);

    // Data port, word accesses only
    assign dmem_enable = ex_mem.is_load || ex_mem.is_store;
    assign dmem_write = ex_mem.is_store;
    assign dmem_addr = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;

    // Same value feeds forwarding and write-back
    assign mem_fwd_data = ex_mem.is_load ? dmem_rdata : ex_mem.result;

    always_ff @(posedge CLK)
    begin
        wb.rd <= ex_mem.rd;
        wb.data <= mem_fwd_data;
        if (reset)
            wb.we <= 1'b0;
        else
            wb.we <= ex_mem.we;
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module execute_stage
    import rv_pkg::*;
(
    input  logic             CLK,
    input  logic             reset,
    input  id_ex_t           id_ex,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc,
    output logic [`XLEN-1:0] ex_fwd_data,
    output ex_mem_t          ex_mem
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] result;
    logic             cond;

    assign op_a = id_ex.rs1_val;
    assign op_b = (id_ex.opcode == OP) ? id_ex.rs2_val : id_ex.imm;
    assign shamt = op_b[4:0];

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb
    begin
        case (id_ex.funct3)
            3'b000:  alu_out = (id_ex.opcode == OP && id_ex.alt) ? op_a - op_b : op_a + op_b;
            3'b001:  alu_out = op_a << shamt;
            3'b010:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            3'b011:  alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
            3'b100:  alu_out = op_a ^ op_b;
            3'b101:
            begin
                if (id_ex.alt)
                    alu_out = $signed(op_a) >>> shamt;
                else
                    alu_out = op_a >> shamt;
            end
            3'b110:  alu_out = op_a | op_b;
            default: alu_out = op_a & op_b;
        endcase
    end

    // Loads, stores and JALR share this adder
    assign addr = id_ex.rs1_val + id_ex.imm;

    always_comb
    begin
        case (id_ex.opcode)
            LUI:         result = id_ex.imm;
            AUIPC:       result = id_ex.pc + id_ex.imm;
            JAL, JALR:   result = id_ex.pc + 32'd4;
            LOAD, STORE: result = addr;
            default:     result = alu_out;
        endcase
    end

    assign ex_fwd_data = result;

    // ----------------------------------------
    // Branch resolution
    // ----------------------------------------
    always_comb
    begin
        case (id_ex.funct3)
            3'b000:  cond = id_ex.rs1_val == id_ex.rs2_val;
            3'b001:  cond = id_ex.rs1_val != id_ex.rs2_val;
            3'b100:  cond = $signed(id_ex.rs1_val) < $signed(id_ex.rs2_val);
            3'b101:  cond = $signed(id_ex.rs1_val) >= $signed(id_ex.rs2_val);
            3'b110:  cond = id_ex.rs1_val < id_ex.rs2_val;
            3'b111:  cond = id_ex.rs1_val >= id_ex.rs2_val;
            default: cond = 1'b0;
        endcase
    end

    assign redirect = id_ex.opcode == JAL || id_ex.opcode == JALR ||
                      (id_ex.opcode == BRANCH && cond);
    assign redirect_pc = (id_ex.opcode == JALR) ? {addr[`XLEN-1:1], 1'b0}
                                                : id_ex.pc + id_ex.imm;

    // Execute to memory register
    always_ff @(posedge CLK)
    begin
        ex_mem.rd <= id_ex.rd;
        ex_mem.result <= result;
        ex_mem.store_data <= id_ex.rs2_val;
        if (reset)
        begin
            ex_mem.we <= 1'b0;
            ex_mem.is_load <= 1'b0;
            ex_mem.is_store <= 1'b0;
        end
        else
        begin
            ex_mem.we <= id_ex.we;
            ex_mem.is_load <= id_ex.opcode == LOAD;
            ex_mem.is_store <= id_ex.opcode == STORE;
        end
    end

endmodule

//--- hazard_unit.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module hazard_unit
    import rv_pkg::*;
(
    input  logic [`REG_ADDR_W-1:0] rs1_index,
    input  logic [`REG_ADDR_W-1:0] rs2_index,
    input  logic                   rs1_used,
    input  logic                   rs2_used,
    input  id_ex_t                 id_ex,
    input  ex_mem_t                ex_mem,
    input  mem_wb_t                wb,
    output fwd_sel_e               fwd_sel_1,
    output fwd_sel_e               fwd_sel_2,
    output logic                   stall
);

    logic load_in_ex;

    // Youngest writer wins
    function automatic fwd_sel_e pick_source(
        input logic [`REG_ADDR_W-1:0] index,
        input id_ex_t                 ex_s,
        input ex_mem_t                mem_s,
        input mem_wb_t                wb_s
    );
        if (index == '0)
            return FWD_RF;
        if (ex_s.we && ex_s.rd == index)
            return FWD_EX;
        if (mem_s.we && mem_s.rd == index)
            return FWD_MEM;
        if (wb_s.we && wb_s.rd == index)
            return FWD_WB;
        return FWD_RF;
    endfunction

    assign fwd_sel_1 = pick_source(rs1_index, id_ex, ex_mem, wb);
    assign fwd_sel_2 = pick_source(rs2_index, id_ex, ex_mem, wb);

    // Load data is not ready until the memory stage
    assign load_in_ex = id_ex.we && id_ex.opcode == LOAD && id_ex.rd != '0;
    assign stall = load_in_ex && ((rs1_used && rs1_index == id_ex.rd) ||
                                  (rs2_used && rs2_index == id_ex.rd));

endmodule

//--- decode_stage.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module decode_stage
    import rv_pkg::*;
(
    input  logic                   CLK,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       if_pc,
    input  instr_u                 if_instr,
    input  logic                   flush,
    input  fwd_sel_e               fwd_sel_1,
    input  fwd_sel_e               fwd_sel_2,
    input  logic [`XLEN-1:0]       ex_fwd_data,
    input  logic [`XLEN-1:0]       mem_fwd_data,
    input  mem_wb_t                wb,
    output logic [`REG_ADDR_W-1:0] rs1_index,
    output logic [`REG_ADDR_W-1:0] rs2_index,
    output logic                   rs1_used,
    output logic                   rs2_used,
    output id_ex_t                 id_ex
);

    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rf_data_1;
    logic [`XLEN-1:0] rf_data_2;
    logic             writes_rd;
    id_ex_t           id_ex_next;

    function automatic logic [`XLEN-1:0] forward_mux(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] rf_val,
        input logic [`XLEN-1:0] ex_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            FWD_EX:  return ex_val;
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign rs1_index = if_instr.r_fmt.rs1;
    assign rs2_index = if_instr.r_fmt.rs2;

    // ----------------------------------------
    // Immediate and register usage
    // ----------------------------------------
    always_comb
    begin
        case (if_instr.r_fmt.opcode)
            STORE:   imm = {{20{if_instr.s_fmt.imm_hi[6]}}, if_instr.s_fmt.imm_hi,
                            if_instr.s_fmt.imm_lo};
            BRANCH:  imm = {{19{if_instr.b_fmt.imm12}}, if_instr.b_fmt.imm12,
                            if_instr.b_fmt.imm11, if_instr.b_fmt.imm10_5,
                            if_instr.b_fmt.imm4_1, 1'b0};
            LUI,
            AUIPC:   imm = {if_instr.u_fmt.imm, 12'b0};
            JAL:     imm = {{11{if_instr.j_fmt.imm20}}, if_instr.j_fmt.imm20,
                            if_instr.j_fmt.imm19_12, if_instr.j_fmt.imm11,
                            if_instr.j_fmt.imm10_1, 1'b0};
            default: imm = {{20{if_instr.i_fmt.imm[11]}}, if_instr.i_fmt.imm};
        endcase
    end

    always_comb
    begin
        rs1_used = if_instr.r_fmt.opcode inside {OP, OP_IMM, JALR, BRANCH, LOAD, STORE};
        rs2_used = if_instr.r_fmt.opcode inside {OP, BRANCH, STORE};
        writes_rd = if_instr.r_fmt.opcode inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR, LOAD};
    end

    register_file u_register_file
    (
        .CLK          (CLK),
        .reset        (reset),
        .read_index_1 (rs1_index),
        .read_index_2 (rs2_index),
        .write_enable (wb.we),
        .write_index  (wb.rd),
        .write_data   (wb.data),
        .read_data_1  (rf_data_1),
        .read_data_2  (rf_data_2)
    );

    always_comb
    begin
        id_ex_next.pc = if_pc;
        id_ex_next.opcode = if_instr.r_fmt.opcode;
        id_ex_next.funct3 = if_instr.r_fmt.funct3;
        id_ex_next.alt = if_instr.r_fmt.funct7[5];
        id_ex_next.rd = if_instr.r_fmt.rd;
        id_ex_next.we = writes_rd;
        id_ex_next.imm = imm;
        id_ex_next.rs1_val = forward_mux(fwd_sel_1, rf_data_1, ex_fwd_data, mem_fwd_data, wb.data);
        id_ex_next.rs2_val = forward_mux(fwd_sel_2, rf_data_2, ex_fwd_data, mem_fwd_data, wb.data);
    end

    // Decode to execute register, a bubble is an OP_IMM with no write
    always_ff @(posedge CLK)
    begin
        if (reset || flush)
        begin
            id_ex.we <= 1'b0;
            id_ex.opcode <= OP_IMM;
        end
        else
            id_ex <= id_ex_next;
    end

endmodule

//--- register_file.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module register_file
(
    input  logic                   CLK,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] read_index_1,
    input  logic [`REG_ADDR_W-1:0] read_index_2,
    input  logic                   write_enable,
    input  logic [`REG_ADDR_W-1:0] write_index,
    input  logic [`XLEN-1:0]       write_data,
    output logic [`XLEN-1:0]       read_data_1,
    output logic [`XLEN-1:0]       read_data_2
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W) - 1];

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 1; i < (1 << `REG_ADDR_W); i++)
                regs[i] <= '0;
        end
        else if (write_enable && write_index != '0)
            regs[write_index] <= write_data;
    end

    assign read_data_1 = (read_index_1 == '0) ? '0 : regs[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : regs[read_index_2];

endmodule

//--- fetch_stage.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module fetch_stage
    import rv_pkg::*;
(
    input  logic             CLK,
    input  logic             reset,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    input  logic             stall,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_data,
    output logic [`XLEN-1:0] if_pc,
    output instr_u           if_instr
);

    // imem_addr is the PC itself
    always_ff @(posedge CLK)
    begin
        if (reset)
            imem_addr <= `RESET_ADDRESS;
        else if (redirect)
            imem_addr <= redirect_pc;
        else if (stall)
            imem_addr <= if_pc;    // refetch the instruction held in decode
        else
            imem_addr <= imem_addr + 32'd4;
    end

    // Fetch to decode register
    always_ff @(posedge CLK)
    begin
        if_pc <= imem_addr;
        if (reset || redirect || stall)
            if_instr <= `NOP_WORD;
        else
            if_instr <= imem_data;
    end

endmodule

//--- rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

    // Major opcodes handled by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    // ----------------------------------------
    // Instruction format views
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_MEM, FWD_WB} fwd_sel_e;

    // ----------------------------------------
    // Stage registers
    // ----------------------------------------
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        opcode_e                opcode;
        logic [2:0]             funct3;
        logic                   alt;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   we;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
    } id_ex_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic                   we;
        logic                   is_load;
        logic                   is_store;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic                   we;
        logic [`XLEN-1:0]       data;
    } mem_wb_t;

endpackage

//--- rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath and register index widths
`define XLEN            32
`define REG_ADDR_W      5

// First fetch address after reset
`define RESET_ADDRESS   32'h0000_0000

// ADDI x0, x0, 0
`define NOP_WORD        32'h0000_0013

`endif
